/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fetch front end with its testbench and runs it.
# The exit status of the simulation is the result of the run.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module fetch_tb -Mdir obj_dir &&
./obj_dir/Vfetch_tb ||
{
    echo "simulation did not pass"
    exit 1
}

/* src.f */
verilog/fetch_pkg.sv
verilog/pc_sequencer.sv
verilog/inst_fetch.sv
verilog/inst_sram.sv
verilog/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

/* testbench/fetch_checker.sv */
/*
 * protocol assertions on the AXI-lite read channels seen by the fetch unit
 * bound into inst_fetch, which sees both sides of each handshake
 * all checks are off while reset is high
 */
`timescale 1ns/1ps

module fetch_checker
    import fetch_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input axi_ar_t      ar,
    input logic         arready,
    input axi_r_t       r,
    input logic         rready,
    input fetch_state_t state
);

    // slave is free whenever a new PC is requested, so pc_change lasts one cycle
    ar_accepted: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid |-> arready)
        else $error("arvalid raised while the slave was not ready");

    // a response only ever answers an outstanding read
    rvalid_only_busy: assert property (@(posedge clk) disable iff (rst)
        r.rvalid |-> state == busy)
        else $error("rvalid without an outstanding read");

    // one read in flight
    no_ar_while_busy: assert property (@(posedge clk) disable iff (rst)
        state == busy |-> !arready)
        else $error("slave ready for an address while a read is outstanding");

    // response drops once taken
    rvalid_dropped: assert property (@(posedge clk) disable iff (rst)
        r.rvalid && rready |=> !r.rvalid)
        else $error("rvalid still high after the handshake");

endmodule

bind inst_fetch fetch_checker u_fetch_checker (
    .clk     (clk),
    .rst     (rst),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready),
    .state   (state)
);

/* testbench/fetch_tb.sv */
/*
 * testbench for the instruction fetch front end
 * fills the SRAM through the load port while reset is high
 * checks every accepted instruction against a PC model and a memory copy
 * inputs change 1 ns after the rising edge, outputs are sampled at the falling edge
 */
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
;

    localparam addr_t RESET_PC       = 32'h8000_0000;
    localparam addr_t MEM_BASE       = 32'h8000_0000;
    localparam int    MEM_WORDS      = 256;
    localparam int    READ_LATENCY   = 2;
    // load and reset take ~272 cycles, ~300 instructions at 5 cycles each plus stalls
    localparam int    TIMEOUT_CYCLES = 4000;

    logic  clk;
    logic  rst;
    logic  stall;
    logic  redirect;
    addr_t redirect_pc;
    logic  load_en;
    addr_t load_addr;
    inst_t load_data;
    addr_t pc;
    inst_t inst;
    logic  inst_valid;

    inst_t       mem_copy [MEM_WORDS];
    logic [31:0] lcg_state = 32'hada0;
    int          accepted = 0;
    int          cycle_count = 0;
    addr_t       first_pc;

    // reference PC state
    addr_t model_pc;
    logic  model_pending;
    addr_t model_target;

    // values seen while stalled with a valid instruction
    logic  hold_valid;
    addr_t held_pc;
    inst_t held_inst;

    fetch_top #(
        .RESET_PC     (RESET_PC),
        .MEM_BASE     (MEM_BASE),
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .pc          (pc),
        .inst        (inst),
        .inst_valid  (inst_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] v;
        v = lcg_next();
        return (v >> 16) % n;
    endfunction

    // word the memory should return for a fetch at addr
    function automatic inst_t expected_word(input addr_t addr);
        int unsigned idx;
        idx = ((addr - MEM_BASE) >> 2) % MEM_WORDS;
        return mem_copy[idx];
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_accepts(input int count);
        int target;
        target = accepted + count;
        while (accepted < target) begin
            step_cycle();
        end
    endtask

    task automatic pulse_redirect(input addr_t addr);
        redirect    = 1'b1;
        redirect_pc = addr;
        step_cycle();
        redirect    = 1'b0;
    endtask

    // reference PC model and comparison of each accepted instruction
    always @(negedge clk) begin
        if (rst) begin
            model_pc      = RESET_PC;
            model_pending = 1'b0;
            hold_valid    = 1'b0;
        end else begin
            if (hold_valid) begin
                check_equal(pc, held_pc, "pc during stall");
                check_equal(inst, held_inst, "inst during stall");
                check_equal({31'b0, inst_valid}, 32'd1, "inst_valid during stall");
            end
            hold_valid = stall && inst_valid;
            held_pc    = pc;
            held_inst  = inst;
            if (inst_valid && !stall) begin
                check_equal(pc, model_pc, "pc");
                check_equal(inst, expected_word(model_pc), "inst");
                if (accepted == 0) begin
                    first_pc = pc;
                end
                accepted++;
                // strobe in the accepting cycle wins over an older pending target
                if (redirect) begin
                    model_pc = redirect_pc;
                end else if (model_pending) begin
                    model_pc = model_target;
                end else begin
                    model_pc = model_pc + 32'd4;
                end
                model_pending = 1'b0;
            end else if (redirect) begin
                model_pending = 1'b1;
            end
            if (redirect) begin
                model_target = redirect_pc;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        addr_t target;
        int    gap;

        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;

        // program load through the boot port
        for (int i = 0; i < MEM_WORDS; i++) begin
            step_cycle();
            load_en     = 1'b1;
            load_addr   = MEM_BASE + addr_t'(i * 4);
            load_data   = lcg_next();
            mem_copy[i] = load_data;
        end
        step_cycle();
        load_en = 1'b0;
        repeat (16) step_cycle();
        rst = 1'b0;

        // first fetch still pending right after reset
        @(negedge clk);
        check_equal({31'b0, inst_valid}, 32'd0, "inst_valid after reset");
        step_cycle();
        wait_accepts(1);
        check_equal(first_pc, RESET_PC, "first accepted pc");

        // straight-line run
        wait_accepts(100);

        // redirects at random points, some land while a read is busy
        for (int i = 0; i < 40; i++) begin
            gap = rand_below(12);
            repeat (gap) step_cycle();
            target = MEM_BASE + addr_t'(rand_below(MEM_WORDS) * 4);
            while (target == pc) begin
                target = MEM_BASE + addr_t'(rand_below(MEM_WORDS) * 4);
            end
            pulse_redirect(target);
        end
        wait_accepts(5);

        // random stall windows
        for (int i = 0; i < 30; i++) begin
            gap = 1 + rand_below(8);
            repeat (gap) step_cycle();
            stall = 1'b1;
            gap = 1 + rand_below(8);
            repeat (gap) step_cycle();
            stall = 1'b0;
        end
        wait_accepts(3);

        // targets past the end of the array
        for (int k = 0; k < 8; k++) begin
            target = MEM_BASE + addr_t'((MEM_WORDS * (1 + k % 3) + rand_below(MEM_WORDS)) * 4);
            while (target == pc) begin
                target = target + 32'd4;
            end
            pulse_redirect(target);
            wait_accepts(4);
        end
        wait_accepts(2);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog/fetch_pkg.sv */
/*
 * shared types for the instruction fetch front end
 * read-channel structs carry only the fields in use, with no rresp and
 * no write channels since memory is never written over AXI-lite
 * addresses are byte addresses and instructions are 32-bit words
 */
package fetch_pkg;

    // byte address, used for the PC and the read address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // word offset from the memory base, i.e. byte offset without bits [1:0]
    typedef logic [29:0] word_idx_t;

    // read master states
    typedef enum logic {
        idle = 1'b0,
        busy = 1'b1
    } fetch_state_t;

    // read-address channel, master to slave
    // arready runs the other way as its own port
    typedef struct packed {
        logic  arvalid;
        addr_t araddr;
    } axi_ar_t;

    // read-data channel, slave to master
    // rready runs the other way as its own port
    typedef struct packed {
        logic  rvalid;
        inst_t rdata;
    } axi_r_t;

endpackage

/* verilog/fetch_top.sv */
/*
 * instruction fetch front end: PC sequencer, AXI-lite fetch unit, SRAM
 * RESET_PC must be nonzero, READ_LATENCY at least 1
 * MEM_WORDS must be a power of two
 * a new PC produces inst_valid READ_LATENCY + 2 cycles later
 */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC     = 32'h8000_0000,
    parameter addr_t MEM_BASE     = 32'h8000_0000,
    parameter int    MEM_WORDS    = 256,
    parameter int    READ_LATENCY = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  load_en,
    input  addr_t load_addr,
    input  inst_t load_data,
    output addr_t pc,
    output inst_t inst,
    output logic  inst_valid
);

    // read channels between fetch unit and memory
    axi_ar_t ar;
    axi_r_t  r;
    logic    arready;
    logic    rready;

    pc_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_pc_sequencer (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_valid  (inst_valid),
        .pc          (pc)
    );

    inst_fetch u_inst_fetch (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready),
        .inst       (inst),
        .inst_valid (inst_valid)
    );

    inst_sram #(
        .MEM_BASE     (MEM_BASE),
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_inst_sram (
        .clk       (clk),
        .rst       (rst),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

/* verilog/inst_fetch.sv */
/*
 * AXI-lite read master that fetches one word each time the PC changes
 * the last fetched PC resets to zero, so the reset PC must be nonzero
 * expects the PC to move only while idle, which the sequencer ensures
 * inst is the slave's held read data and is valid while inst_valid is high
 */
`timescale 1ns/1ps

module inst_fetch
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  addr_t   pc,
    output axi_ar_t ar,
    input  logic    arready,
    input  axi_r_t  r,
    output logic    rready,
    output inst_t   inst,
    output logic    inst_valid
);

    fetch_state_t state;
    fetch_state_t state_next;
    addr_t        last_pc;
    logic         pc_change;
    logic         state_idle;
    logic         state_busy;
    logic         ar_fire;
    logic         r_fire;

    // new fetch request whenever the PC differs from the last one sent
    assign pc_change = (pc != last_pc);

    assign state_idle = (state == idle);
    assign state_busy = (state == busy);

    // address phase only from idle
    always_comb begin
        ar.arvalid = state_idle & pc_change;
        ar.araddr  = pc;
    end

    // ready for data exactly while waiting for it
    assign rready = state_busy;

    assign ar_fire = ar.arvalid & arready;
    assign r_fire  = r.rvalid & rready;

    // idle -> busy on address handshake, back on data handshake
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (ar_fire) begin
                    state_next = busy;
                end
            end
            busy: begin
                if (r_fire) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // remember the PC once its read is accepted
    // with arready high while idle this is the same edge the change shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            last_pc <= '0;
        end else if (ar_fire) begin
            last_pc <= pc;
        end
    end

    // word belongs to pc once back in idle with nothing new pending
    assign inst_valid = state_idle & ~pc_change;
    assign inst       = r.rdata;

endmodule

/* verilog/inst_sram.sv */
/*
 * read-only AXI-lite instruction memory with a fixed read latency
 * MEM_WORDS must be a power of two, addresses wrap modulo the array
 * byte address bits [1:0] are ignored, READ_LATENCY must be at least 1
 * one read in flight at a time, array contents come from the load port
 */
`timescale 1ns/1ps

module inst_sram
    import fetch_pkg::*;
#(
    parameter addr_t MEM_BASE     = 32'h8000_0000,
    parameter int    MEM_WORDS    = 256,
    parameter int    READ_LATENCY = 2
) (
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    output logic    arready,
    output axi_r_t  r,
    input  logic    rready,
    input  logic    load_en,
    input  addr_t   load_addr,
    input  inst_t   load_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(READ_LATENCY + 1);

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    inst_t mem [MEM_WORDS];

    idx_t  rd_idx;
    cnt_t  lat_cnt;
    logic  outstanding;
    logic  rvalid_q;
    inst_t rdata_q;
    logic  ar_fire;
    logic  r_fire;
    logic  data_due;

    // byte address to array index, wrapping past the end
    function automatic idx_t to_index(addr_t addr);
        addr_t     byte_off;
        word_idx_t word_off;
        byte_off = addr - MEM_BASE;
        word_off = byte_off[31:2];
        return word_off[IDX_W-1:0];
    endfunction

    // accept a new address only with nothing outstanding
    assign arready = ~outstanding;

    assign ar_fire = ar.arvalid & arready;
    assign r_fire  = rvalid_q & rready;

    // latency expired, read the array this cycle
    assign data_due = outstanding & ~rvalid_q & (lat_cnt == '0);

    // read tracking: outstanding flag, latency counter, rvalid
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
            rvalid_q    <= 1'b0;
            lat_cnt     <= '0;
        end else begin
            if (ar_fire) begin
                outstanding <= 1'b1;
                lat_cnt     <= cnt_t'(READ_LATENCY - 1);
            end else if (r_fire) begin
                outstanding <= 1'b0;
            end else if (outstanding && lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end

            // rvalid holds until the master takes it
            if (data_due) begin
                rvalid_q <= 1'b1;
            end else if (r_fire) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // captured index and held read data
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_idx <= to_index(ar.araddr);
        end
        if (data_due) begin
            rdata_q <= mem[rd_idx];
        end
    end

    // boot-time fill, takes effect immediately
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[to_index(load_addr)] <= load_data;
        end
    end

    always_comb begin
        r.rvalid = rvalid_q;
        r.rdata  = rdata_q;
    end

endmodule

/* verilog/pc_sequencer.sv */
/*
 * program counter for the fetch front end
 * advances by four on each accepted instruction (inst_valid high, stall low)
 * a redirect strobe is held until the next advance and wins over the increment
 * a redirect to the PC that is already current does not cause a refetch
 */
`timescale 1ns/1ps

module pc_sequencer
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  inst_valid,
    output addr_t pc
);

    logic  advance;
    logic  take_redirect;
    logic  redir_pending;
    addr_t redir_target;
    addr_t next_target;
    addr_t pc_q;

    // instruction accepted this cycle
    assign advance = inst_valid & ~stall;

    // a strobe in the same cycle as an advance counts right away
    assign take_redirect = redirect | redir_pending;
    assign next_target   = redirect ? redirect_pc : redir_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (advance) begin
            if (take_redirect) begin
                pc_q <= next_target;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // pending flag, consumed by the next advance
    always_ff @(posedge clk) begin
        if (rst) begin
            redir_pending <= 1'b0;
        end else if (advance) begin
            redir_pending <= 1'b0;
        end else if (redirect) begin
            redir_pending <= 1'b1;
        end
    end

    // latest strobe overwrites an older pending target
    always_ff @(posedge clk) begin
        if (redirect) begin
            redir_target <= redirect_pc;
        end
    end

    assign pc = pc_q;

endmodule
